// ==== accel_subsys.f ====
+incdir+hw
hw/accel_pkg.sv
hw/slot_fifo.sv
hw/accel_csr.sv
hw/pkt_rd_dma.sv
hw/byte_pattern_matcher.sv
hw/ip_blocklist.sv
hw/accel_subsys_top.sv
verification/accel_subsys_properties.sv
verification/accel_subsys_tb.sv

// ==== hw/accel_csr.sv ====
`include "accel_defs.svh"

module accel_csr import accel_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               io_en,
  input  logic                               io_wen,
  input  logic [3:0]                         io_strb,
  input  logic [6:0]                         io_addr,
  input  logic [31:0]                        io_wr_data,
  output logic [31:0]                        io_rd_data,
  output logic                               io_rd_valid,
  output logic                               desc_push,
  output desc_t                              desc,
  output logic                               meta_push,
  output meta_t                              meta,
  input  logic                               result_valid,
  input  result_t                            result,
  output logic                               result_pop,
  output logic [31:0]                        ip_addr,
  output logic                               ip_start,
  input  logic                               ip_hit,
  input  logic                               ip_done,
  output logic                               bl_wr_en,
  output logic [$clog2(`ACC_BL_ENTRIES)-1:0] bl_wr_idx,
  output logic [31:0]                        bl_wr_data
);

  localparam int BL_IDX_W = $clog2(`ACC_BL_ENTRIES);

  logic [`ACC_LEN_W-1:0]  len_reg;
  logic [`ACC_ADDR_W-1:0] addr_reg;
  logic [31:0]            meta_reg;
  logic [31:0]            src_ip_reg;
  logic                   start_q;
  logic                   release_q;
  logic                   lookup_q;
  logic                   rd_stall;
  logic                   rd_valid_q;
  logic [31:0]            rd_data_q;
  logic                   wr_acc;
  logic                   rd_acc;
  logic                   bl_sel;

  assign wr_acc = io_en && io_wen;
  assign rd_acc = io_en && !io_wen;
  assign bl_sel = (io_addr >= `ACC_REG_BL_BASE);

  // Start pushes both queues together so descriptor and metadata stay paired
  assign desc        = '{start: addr_reg, len: len_reg};
  assign meta        = meta_t'(meta_reg);
  assign desc_push   = start_q;
  assign meta_push   = start_q;
  assign result_pop  = release_q;
  assign ip_addr     = src_ip_reg;
  assign ip_start    = lookup_q;
  assign io_rd_data  = rd_data_q;
  assign io_rd_valid = rd_valid_q;

  always_ff @(posedge clk) begin
    if (wr_acc) begin
      case (io_addr)
        `ACC_REG_LEN: begin
          if (io_strb[0]) len_reg[7:0] <= io_wr_data[7:0];
          if (io_strb[1]) len_reg[`ACC_LEN_W-1:8] <= io_wr_data[`ACC_LEN_W-1:8];
        end
        `ACC_REG_ADDR: begin
          if (io_strb[0]) addr_reg[7:0] <= io_wr_data[7:0];
          if (io_strb[1]) addr_reg[`ACC_ADDR_W-1:8] <= io_wr_data[`ACC_ADDR_W-1:8];
        end
        `ACC_REG_META: begin
          for (int b = 0; b < 4; b++) begin
            if (io_strb[b]) meta_reg[8*b +: 8] <= io_wr_data[8*b +: 8];
          end
        end
        `ACC_REG_SRC_IP: begin
          for (int b = 0; b < 4; b++) begin
            if (io_strb[b]) src_ip_reg[8*b +: 8] <= io_wr_data[8*b +: 8];
          end
        end
        default: ;
      endcase
      if (bl_sel) begin
        bl_wr_idx  <= io_addr[2 +: BL_IDX_W];
        bl_wr_data <= io_wr_data;
      end
    end
  end

  // One-cycle command pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      start_q   <= 1'b0;
      release_q <= 1'b0;
      lookup_q  <= 1'b0;
      bl_wr_en  <= 1'b0;
    end else begin
      start_q   <= wr_acc && (io_addr == `ACC_REG_CTRL) && io_strb[0] && io_wr_data[0];
      release_q <= wr_acc && (io_addr == `ACC_REG_CTRL) && io_strb[0] && io_wr_data[1];
      lookup_q  <= wr_acc && (io_addr == `ACC_REG_SRC_IP);
      bl_wr_en  <= wr_acc && bl_sel;
    end
  end

  // Status read waits for the lookup, including the cycle before it starts
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
      rd_stall   <= 1'b0;
    end else if (rd_stall) begin
      rd_valid_q <= ip_done;
      rd_stall   <= !ip_done;
    end else if (rd_acc && (io_addr == `ACC_REG_IP_STATUS) && (lookup_q || !ip_done)) begin
      rd_valid_q <= 1'b0;
      rd_stall   <= 1'b1;
    end else begin
      rd_valid_q <= rd_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_stall) begin
      rd_data_q <= {31'b0, ip_hit};
    end else if (rd_acc) begin
      case (io_addr)
        `ACC_REG_CTRL:      rd_data_q <= {31'b0, result_valid};
        `ACC_REG_LEN:       rd_data_q <= 32'(len_reg);
        `ACC_REG_ADDR:      rd_data_q <= 32'(addr_reg);
        `ACC_REG_META:      rd_data_q <= meta_reg;
        `ACC_REG_RESULT:    rd_data_q <= {result.matched, 29'b0, result.rule_idx};
        `ACC_REG_STATE:     rd_data_q <= {result.end_state, result.slot};
        `ACC_REG_SRC_IP:    rd_data_q <= src_ip_reg;
        `ACC_REG_IP_STATUS: rd_data_q <= {31'b0, ip_hit};
        default:            rd_data_q <= '0;
      endcase
    end
  end

endmodule

// ==== hw/accel_defs.svh ====
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Packet memory line and descriptor field widths
`define ACC_DATA_W        32
`define ACC_ADDR_W        10
`define ACC_LEN_W         14

// Queue depths, rule count and matcher input buffer size
`define ACC_SLOT_COUNT    16
`define ACC_RULE_COUNT    4
`define ACC_MATCH_CREDITS 4
`define ACC_BL_ENTRIES    8

// Host register map, byte offsets on io_addr
`define ACC_REG_CTRL      7'h00
`define ACC_REG_LEN       7'h04
`define ACC_REG_ADDR      7'h08
`define ACC_REG_META      7'h0C
`define ACC_REG_RESULT    7'h10
`define ACC_REG_STATE     7'h14
`define ACC_REG_SRC_IP    7'h40
`define ACC_REG_IP_STATUS 7'h50
`define ACC_REG_BL_BASE   7'h60

`endif

// ==== hw/accel_pkg.sv ====
`include "accel_defs.svh"

package accel_pkg;

  // Packet request as queued by the host
  typedef struct packed {
    logic [`ACC_ADDR_W-1:0] start;
    logic [`ACC_LEN_W-1:0]  len;
  } desc_t;

  // Matcher context, preamble byte 0 sits in preamble[7:0] and is the oldest
  typedef struct packed {
    logic [23:0] preamble;
    logic [7:0]  slot;
  } meta_t;

  // Per-packet verdict
  typedef struct packed {
    logic                               matched;
    logic [$clog2(`ACC_RULE_COUNT)-1:0] rule_idx;
    logic [23:0]                        end_state;
    logic [7:0]                         slot;
  } result_t;

endpackage

// ==== hw/accel_subsys_top.sv ====
`include "accel_defs.svh"

module accel_subsys_top import accel_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               io_en,
  input  logic                               io_wen,
  input  logic [3:0]                         io_strb,
  input  logic [6:0]                         io_addr,
  input  logic [31:0]                        io_wr_data,
  output logic [31:0]                        io_rd_data,
  output logic                               io_rd_valid,
  input  logic                               rule_wr_en,
  input  logic [$clog2(`ACC_RULE_COUNT)-1:0] rule_wr_addr,
  input  logic [31:0]                        rule_wr_data,
  output logic                               mem_rd_en,
  output logic [`ACC_ADDR_W-1:0]             mem_rd_addr,
  input  logic [`ACC_DATA_W-1:0]             mem_rd_data
);

  logic                               desc_push, desc_valid, desc_ready;
  desc_t                              desc_in, desc_out;
  logic                               meta_push, meta_valid, meta_ready;
  meta_t                              meta_in, meta_out;
  logic                               result_push, result_ready, result_valid, result_pop;
  result_t                            result_in, result_out;
  logic [31:0]                        ip_addr;
  logic                               ip_start, ip_hit, ip_done;
  logic                               bl_wr_en;
  logic [$clog2(`ACC_BL_ENTRIES)-1:0] bl_wr_idx;
  logic [31:0]                        bl_wr_data;
  logic                               beat_valid, beat_last, credit;
  logic [`ACC_DATA_W-1:0]             beat_data;
  logic [2:0]                         beat_bytes;

  accel_csr accel_csr_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc_push(desc_push), .desc(desc_in),
    .meta_push(meta_push), .meta(meta_in),
    .result_valid(result_valid), .result(result_out), .result_pop(result_pop),
    .ip_addr(ip_addr), .ip_start(ip_start), .ip_hit(ip_hit), .ip_done(ip_done),
    .bl_wr_en(bl_wr_en), .bl_wr_idx(bl_wr_idx), .bl_wr_data(bl_wr_data)
  );

  // Host keeps unreleased packets within the queue depth, so pushes always fit
  slot_fifo #(.payload_t(desc_t), .DEPTH(`ACC_SLOT_COUNT)) desc_q (
    .clk(clk), .rst(rst),
    .in_valid(desc_push), .in_data(desc_in), .in_ready(),
    .out_valid(desc_valid), .out_data(desc_out), .out_ready(desc_ready)
  );

  slot_fifo #(.payload_t(meta_t), .DEPTH(`ACC_SLOT_COUNT)) meta_q (
    .clk(clk), .rst(rst),
    .in_valid(meta_push), .in_data(meta_in), .in_ready(),
    .out_valid(meta_valid), .out_data(meta_out), .out_ready(meta_ready)
  );

  slot_fifo #(.payload_t(result_t), .DEPTH(`ACC_SLOT_COUNT)) result_q (
    .clk(clk), .rst(rst),
    .in_valid(result_push), .in_data(result_in), .in_ready(result_ready),
    .out_valid(result_valid), .out_data(result_out), .out_ready(result_pop)
  );

  pkt_rd_dma pkt_rd_dma_i (
    .clk(clk), .rst(rst),
    .desc_valid(desc_valid), .desc(desc_out), .desc_ready(desc_ready),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .beat_valid(beat_valid), .beat_data(beat_data),
    .beat_last(beat_last), .beat_bytes(beat_bytes),
    .credit(credit)
  );

  byte_pattern_matcher byte_pattern_matcher_i (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .beat_valid(beat_valid), .beat_data(beat_data),
    .beat_last(beat_last), .beat_bytes(beat_bytes),
    .credit(credit),
    .meta_valid(meta_valid), .meta(meta_out), .meta_ready(meta_ready),
    .result_push(result_push), .result(result_in), .result_ready(result_ready)
  );

  ip_blocklist ip_blocklist_i (
    .clk(clk), .rst(rst),
    .wr_en(bl_wr_en), .wr_idx(bl_wr_idx), .wr_data(bl_wr_data),
    .addr(ip_addr), .start(ip_start), .hit(ip_hit), .done(ip_done)
  );

endmodule

// ==== hw/byte_pattern_matcher.sv ====
`include "accel_defs.svh"

module byte_pattern_matcher import accel_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               rule_wr_en,
  input  logic [$clog2(`ACC_RULE_COUNT)-1:0] rule_wr_addr,
  input  logic [31:0]                        rule_wr_data,
  input  logic                               beat_valid,
  input  logic [`ACC_DATA_W-1:0]             beat_data,
  input  logic                               beat_last,
  input  logic [2:0]                         beat_bytes,
  output logic                               credit,
  input  logic                               meta_valid,
  input  meta_t                              meta,
  output logic                               meta_ready,
  output logic                               result_push,
  output result_t                            result,
  input  logic                               result_ready
);

  localparam int RULE_N = `ACC_RULE_COUNT;
  localparam int IDX_W  = $clog2(RULE_N);

  typedef struct packed {
    logic [`ACC_DATA_W-1:0] data;
    logic                   last;
    logic [2:0]             bytes;
  } beat_t;

  logic [31:0]       rules [RULE_N];
  beat_t             buf_in;
  beat_t             buf_out;
  logic              buf_valid;
  logic              consume;
  logic              in_pkt;
  logic              s1_valid;
  logic              s1_go;
  beat_t             s1_beat;
  logic              s1_first;
  meta_t             s1_meta;
  logic [23:0]       hist_q;
  logic [7:0]        slot_q;
  logic [RULE_N-1:0] hits_q;
  logic [23:0]       hist_base;
  logic [55:0]       stream;
  logic [RULE_N-1:0] beat_hits;
  logic [RULE_N-1:0] pkt_hits;
  logic [IDX_W-1:0]  low_idx;
  logic [23:0]       hist_next;
  logic [7:0]        slot_cur;

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rules[rule_wr_addr] <= rule_wr_data;
    end
  end

  assign buf_in = '{data: beat_data, last: beat_last, bytes: beat_bytes};

  // Sized to the DMA credit count, so in_ready is never low on a beat
  slot_fifo #(
    .payload_t (beat_t),
    .DEPTH     (`ACC_MATCH_CREDITS)
  ) beat_buf (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (beat_valid),
    .in_data   (buf_in),
    .in_ready  (),
    .out_valid (buf_valid),
    .out_data  (buf_out),
    .out_ready (consume)
  );

  // A last beat waits in stage 1 while an unaccepted result is held
  assign s1_go      = s1_valid && !(s1_beat.last && result_push && !result_ready);
  assign consume    = buf_valid && (in_pkt || meta_valid) && (!s1_valid || s1_go);
  assign meta_ready = consume && !in_pkt;

  // Byte stream is history then beat, oldest byte lowest
  always_comb begin
    hist_base = s1_first ? s1_meta.preamble : hist_q;
    slot_cur  = s1_first ? s1_meta.slot : slot_q;
    stream    = {s1_beat.data, hist_base};
    beat_hits = '0;
    for (int j = 0; j < 4; j++) begin
      for (int r = 0; r < RULE_N; r++) begin
        if ((j < s1_beat.bytes) && (stream[8*j +: 32] == rules[r])) begin
          beat_hits[r] = 1'b1;
        end
      end
    end
    pkt_hits  = s1_first ? beat_hits : (hits_q | beat_hits);
    hist_next = stream[8*s1_beat.bytes +: 24];
    low_idx   = '0;
    for (int r = RULE_N - 1; r >= 0; r--) begin
      if (pkt_hits[r]) low_idx = IDX_W'(r);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credit      <= 1'b0;
      in_pkt      <= 1'b0;
      s1_valid    <= 1'b0;
      result_push <= 1'b0;
    end else begin
      credit <= consume;
      if (consume) begin
        in_pkt   <= !buf_out.last;
        s1_valid <= 1'b1;
      end else if (s1_go) begin
        s1_valid <= 1'b0;
      end
      if (result_ready) result_push <= 1'b0;
      if (s1_go && s1_beat.last) result_push <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (consume) begin
      s1_beat  <= buf_out;
      s1_first <= !in_pkt;
      s1_meta  <= meta;
    end
    if (s1_go) begin
      hist_q <= hist_next;
      slot_q <= slot_cur;
      hits_q <= pkt_hits;
    end
    if (s1_go && s1_beat.last) begin
      result <= '{matched: |pkt_hits, rule_idx: low_idx, end_state: hist_next, slot: slot_cur};
    end
  end

endmodule

// ==== hw/ip_blocklist.sv ====
`include "accel_defs.svh"

module ip_blocklist (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               wr_en,
  input  logic [$clog2(`ACC_BL_ENTRIES)-1:0] wr_idx,
  input  logic [31:0]                        wr_data,
  input  logic [31:0]                        addr,
  input  logic                               start,
  output logic                               hit,
  output logic                               done
);

  localparam int N     = `ACC_BL_ENTRIES;
  localparam int CNT_W = $clog2(N) + 1;

  logic [31:0]      entries [N];
  logic [CNT_W-1:0] step;
  logic             busy;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_idx] <= wr_data;
    end
  end

  // One entry per cycle, then one more cycle to raise done
  // Out of reset there is no pending lookup, so done reads high
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      step <= '0;
      hit  <= 1'b0;
      done <= 1'b1;
    end else if (start) begin
      busy <= 1'b1;
      step <= '0;
      hit  <= 1'b0;
      done <= 1'b0;
    end else if (busy) begin
      if (step == CNT_W'(N)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else begin
        if (entries[step[CNT_W-2:0]] == addr) hit <= 1'b1;
        step <= step + 1'b1;
      end
    end
  end

endmodule

// ==== hw/pkt_rd_dma.sv ====
`include "accel_defs.svh"

module pkt_rd_dma import accel_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   desc_valid,
  input  desc_t                  desc,
  output logic                   desc_ready,
  output logic                   mem_rd_en,
  output logic [`ACC_ADDR_W-1:0] mem_rd_addr,
  input  logic [`ACC_DATA_W-1:0] mem_rd_data,
  output logic                   beat_valid,
  output logic [`ACC_DATA_W-1:0] beat_data,
  output logic                   beat_last,
  output logic [2:0]             beat_bytes,
  input  logic                   credit
);

  localparam int                    CR_W     = $clog2(`ACC_MATCH_CREDITS + 1);
  localparam logic [`ACC_LEN_W-1:0] LINE_LEN = `ACC_DATA_W / 8;
  localparam logic [`ACC_LEN_W-1:0] LEN_MIN  = 1;

  logic                   active;
  logic [`ACC_ADDR_W-1:0] addr_q;
  logic [`ACC_LEN_W-1:0]  remain_q;
  logic [CR_W-1:0]        credit_cnt;
  logic                   take;
  logic                   issue;
  logic                   issue_last;
  logic [2:0]             issue_bytes;

  // Next descriptor only once the current one has issued its last read
  assign desc_ready  = !active;
  assign take        = desc_valid && desc_ready;
  assign issue       = active && (credit_cnt != '0);
  assign issue_last  = (remain_q <= LINE_LEN);
  assign issue_bytes = issue_last ? remain_q[2:0] : 3'(`ACC_DATA_W / 8);

  assign mem_rd_en   = issue;
  assign mem_rd_addr = addr_q;
  // Memory answers one cycle after the read, in step with beat_valid
  assign beat_data   = mem_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      beat_valid <= 1'b0;
      credit_cnt <= CR_W'(`ACC_MATCH_CREDITS);
    end else begin
      beat_valid <= issue;
      credit_cnt <= credit_cnt - CR_W'(issue) + CR_W'(credit);
      if (take) begin
        active <= 1'b1;
      end else if (issue && issue_last) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q   <= desc.start;
      remain_q <= (desc.len == '0) ? LEN_MIN : desc.len;
    end else if (issue) begin
      addr_q   <= addr_q + 1'b1;
      remain_q <= remain_q - LINE_LEN;
    end
    beat_last  <= issue_last;
    beat_bytes <= issue_bytes;
  end

endmodule

// ==== hw/slot_fifo.sv ====
module slot_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own, DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// ==== verification/accel_subsys_properties.sv ====
`include "accel_defs.svh"

module accel_subsys_properties #(
  parameter int CR_W = $clog2(`ACC_MATCH_CREDITS + 1)
) (
  input logic            clk,
  input logic            rst,
  input logic            beat_valid,
  input logic            credit,
  input logic [CR_W-1:0] credit_cnt
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [CR_W-1:0] CR_MAX = CR_W'(`ACC_MATCH_CREDITS);

  logic [CR_W-1:0] beats_held;

  // Beats handed to the matcher whose credit has not come back yet
  always_ff @(posedge clk) begin
    if (rst) begin
      beats_held <= '0;
    end else begin
      beats_held <= beats_held + CR_W'(beat_valid) - CR_W'(credit);
    end
  end

  // Credits in hand never exceed the matcher buffer depth
  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CR_MAX)
    else $error("DMA credit count %0d above buffer depth", credit_cnt);

  // A returned credit must belong to a beat that is still outstanding
  credit_has_owner: assert property (@(posedge clk) disable iff (rst)
    credit |-> credit_cnt < CR_MAX)
    else $error("Credit returned while all credits were home");

  // Matcher frees a buffer slot only after a beat has landed in it
  credit_after_beat: assert property (@(posedge clk) disable iff (rst)
    credit |-> beats_held != '0)
    else $error("Credit returned with no beat held by the matcher");

endmodule

bind pkt_rd_dma accel_subsys_properties dma_credit_props (
  .clk        (clk),
  .rst        (rst),
  .beat_valid (beat_valid),
  .credit     (credit),
  .credit_cnt (credit_cnt)
);

// ==== verification/accel_subsys_tb.sv ====
`include "accel_defs.svh"

module accel_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TABLE_N    = 7;
  localparam int QUEUED_N   = 4;
  localparam int MEM_LINES  = 1 << `ACC_ADDR_W;
  localparam int POLL_LIMIT = 200;
  localparam int READ_LIMIT = 50;

  // Planted rule -1 means no pattern
  typedef struct {
    string       name;
    int          start;
    int          len;
    logic [23:0] pre;
    logic [7:0]  slot;
    int          rule_a;
    int          off_a;
    int          rule_b;
    int          off_b;
    bit          exp_matched;
    int          exp_idx;
  } pkt_case_t;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   io_en;
  logic                   io_wen;
  logic [3:0]             io_strb;
  logic [6:0]             io_addr;
  logic [31:0]            io_wr_data;
  logic [31:0]            io_rd_data;
  logic                   io_rd_valid;
  logic                   rule_wr_en;
  logic [1:0]             rule_wr_addr;
  logic [31:0]            rule_wr_data;
  logic                   mem_rd_en;
  logic [`ACC_ADDR_W-1:0] mem_rd_addr;
  logic [`ACC_DATA_W-1:0] mem_rd_data;

  logic [31:0] pmem [MEM_LINES];
  logic [31:0] rule_val [`ACC_RULE_COUNT];
  pkt_case_t   cases [TABLE_N];
  int          test_count;
  int          fail_tests;
  bit          test_bad;

  accel_subsys_top accel_subsys_top_i (.*);

  always #10 clk = ~clk;

  // Packet memory with one cycle of read latency
  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= pmem[mem_rd_addr];
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Stream seen by the matcher is the preamble then the packet bytes
  function automatic logic [7:0] stream_byte(pkt_case_t c, int s);
    int k;
    k = s - 3;
    if (s < 3) begin
      return c.pre[8*s +: 8];
    end
    return pmem[c.start + k / 4][8*(k % 4) +: 8];
  endfunction

  function automatic logic [23:0] expected_end_state(pkt_case_t c);
    int n;
    n = c.len + 3;
    return {stream_byte(c, n - 1), stream_byte(c, n - 2), stream_byte(c, n - 3)};
  endfunction

  task automatic plant_pattern(int start, int off, logic [31:0] pattern);
    int k;
    for (int i = 0; i < 4; i++) begin
      k = off + i;
      if (k >= 0) begin
        pmem[start + k / 4][8*(k % 4) +: 8] = pattern[8*i +: 8];
      end
    end
  endtask

  task automatic fill_memory;
    logic [31:0] state;
    state = 32'ha392;
    for (int a = 0; a < MEM_LINES; a++) begin
      state = xorshift(state);
      pmem[a] = state;
    end
  endtask

  task automatic fill_table;
    cases[0] = '{"mid_packet",     16,  40, 24'h1A2B3C, 8'h01,  0, 17, -1,  0, 1'b1, 0};
    cases[1] = '{"line_cross",     40,  23, 24'h445566, 8'h02,  3,  6, -1,  0, 1'b1, 3};
    cases[2] = '{"preamble_start", 64,  12, 24'h3CA577, 8'h03,  2, -2, -1,  0, 1'b1, 2};
    cases[3] = '{"two_rules",      80,  33, 24'h0F1E2D, 8'h04,  3,  3,  1, 20, 1'b1, 1};
    cases[4] = '{"no_match",       100, 31, 24'h778899, 8'h05, -1,  0, -1,  0, 1'b0, 0};
    cases[5] = '{"tail_ignored",   120, 10, 24'h102030, 8'h06,  0,  8, -1,  0, 1'b0, 0};
    cases[6] = '{"short_pkt",      130,  2, 24'hA1B2C3, 8'h07, -1,  0, -1,  0, 1'b0, 0};
  endtask

  task automatic io_write(logic [6:0] addr, logic [31:0] data, logic [3:0] strb);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_addr    <= addr;
    io_wr_data <= data;
    io_strb    <= strb;
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  // Address stays on the bus until the response, which a stalled read needs
  task automatic io_read(input logic [6:0] addr, output logic [31:0] data, output int waited);
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(posedge clk);
    io_en  <= 1'b0;
    waited = 0;
    data   = '0;
    do begin
      @(negedge clk);
      waited++;
    end while (!io_rd_valid && waited < READ_LIMIT);
    if (!io_rd_valid) begin
      $display("No read response from register 0x%02h after %0d cycles", addr, waited);
      test_bad = 1'b1;
    end else begin
      data = io_rd_data;
    end
  endtask

  task automatic compare(string test, string field, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s: %s expected 0x%0h actual 0x%0h", test, field, expected, actual);
      test_bad = 1'b1;
    end
  endtask

  task automatic finish_test(string name);
    test_count++;
    if (test_bad) begin
      fail_tests++;
      $display("FAIL %s", name);
    end else begin
      $display("PASS %s", name);
    end
    test_bad = 1'b0;
  endtask

  task automatic stage_packet(pkt_case_t c);
    io_write(`ACC_REG_LEN, 32'(c.len), 4'hF);
    io_write(`ACC_REG_ADDR, 32'(c.start), 4'hF);
    io_write(`ACC_REG_META, {c.pre, c.slot}, 4'hF);
    io_write(`ACC_REG_CTRL, 32'h1, 4'h1);
  endtask

  task automatic collect_result(pkt_case_t c);
    logic [31:0] d;
    int          waited;
    int          polls;
    polls = 0;
    d     = '0;
    while (d[0] !== 1'b1 && polls < POLL_LIMIT) begin
      io_read(`ACC_REG_CTRL, d, waited);
      polls++;
    end
    if (d[0] !== 1'b1) begin
      $display("No result posted for %s after %0d polls", c.name, polls);
      test_bad = 1'b1;
    end else begin
      io_read(`ACC_REG_RESULT, d, waited);
      compare(c.name, "matched", 32'(c.exp_matched), 32'(d[31]));
      if (c.exp_matched) begin
        compare(c.name, "rule index", 32'(c.exp_idx), 32'(d[1:0]));
      end
      io_read(`ACC_REG_STATE, d, waited);
      compare(c.name, "end state", 32'(expected_end_state(c)), 32'(d[31:8]));
      compare(c.name, "slot", 32'(c.slot), 32'(d[7:0]));
      io_write(`ACC_REG_CTRL, 32'h2, 4'h1);
    end
  endtask

  task automatic check_readback;
    logic [31:0] d;
    int          waited;
    io_write(`ACC_REG_LEN, 32'hFFFF_3A5C, 4'hF);
    io_write(`ACC_REG_ADDR, 32'h0000_FE7B, 4'hF);
    io_write(`ACC_REG_META, 32'h1122_3344, 4'hF);
    io_write(`ACC_REG_META, 32'hAABB_CCDD, 4'b0101);
    io_write(`ACC_REG_SRC_IP, 32'hC0A8_0001, 4'hF);
    io_read(`ACC_REG_LEN, d, waited);
    compare("register_readback", "LEN", 32'hFFFF_3A5C & 32'((1 << `ACC_LEN_W) - 1), d);
    io_read(`ACC_REG_ADDR, d, waited);
    compare("register_readback", "ADDR", 32'h0000_FE7B & 32'((1 << `ACC_ADDR_W) - 1), d);
    // Bytes 0 and 2 come from the second write, bytes 1 and 3 stay from the first
    io_read(`ACC_REG_META, d, waited);
    compare("register_readback", "META", 32'h11BB_33DD, d);
    io_read(`ACC_REG_SRC_IP, d, waited);
    compare("register_readback", "SRC_IP", 32'hC0A8_0001, d);
    finish_test("register_readback");
  endtask

  task automatic lookup_source(string name, logic [31:0] ip, logic [31:0] exp_hit);
    logic [31:0] d;
    int          waited;
    io_write(`ACC_REG_SRC_IP, ip, 4'hF);
    io_read(`ACC_REG_IP_STATUS, d, waited);
    compare(name, "hit", exp_hit, d);
    if (waited < 2) begin
      $display("Status read in %s returned without waiting for the lookup", name);
      test_bad = 1'b1;
    end
    finish_test(name);
  endtask

  initial begin
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = 4'h0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data  = '0;
    test_count   = 0;
    fail_tests   = 0;
    test_bad     = 1'b0;
    rule_val[0]  = 32'hDEADBEEF;
    rule_val[1]  = 32'hCAFEF00D;
    rule_val[2]  = 32'h5AC33CA5;
    rule_val[3]  = 32'h0BADC0DE;
    fill_table();
    fill_memory();
    foreach (cases[i]) begin
      if (cases[i].rule_a >= 0) begin
        plant_pattern(cases[i].start, cases[i].off_a, rule_val[cases[i].rule_a]);
      end
      if (cases[i].rule_b >= 0) begin
        plant_pattern(cases[i].start, cases[i].off_b, rule_val[cases[i].rule_b]);
      end
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < `ACC_RULE_COUNT; r++) begin
      @(posedge clk);
      rule_wr_en   <= 1'b1;
      rule_wr_addr <= 2'(r);
      rule_wr_data <= rule_val[r];
    end
    @(posedge clk);
    rule_wr_en <= 1'b0;

    check_readback();
    for (int i = 0; i < `ACC_BL_ENTRIES; i++) begin
      io_write(`ACC_REG_BL_BASE + 7'(4 * i), 32'h0A00_0100 + 32'(i * 7), 4'hF);
    end
    lookup_source("blocklist_listed", 32'h0A00_0100 + 32'(5 * 7), 32'h1);
    lookup_source("blocklist_unlisted", 32'h0808_0808, 32'h0);

    for (int i = 0; i < TABLE_N; i++) begin
      stage_packet(cases[i]);
      collect_result(cases[i]);
      finish_test(cases[i].name);
    end

    // Several packets in flight, results come back in start order
    for (int i = 0; i < QUEUED_N; i++) begin
      stage_packet(cases[i]);
    end
    for (int i = 0; i < QUEUED_N; i++) begin
      collect_result(cases[i]);
      finish_test({"queued_", cases[i].name});
    end

    $display("Tests run %0d, passed %0d, failed %0d",
             test_count, test_count - fail_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the longest packet in the table
  initial begin
    int max_len;
    int limit;
    @(posedge clk);
    max_len = 0;
    foreach (cases[i]) begin
      if (cases[i].len > max_len) begin
        max_len = cases[i].len;
      end
    end
    limit = TABLE_N * (max_len + 200);
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Test failed");
    $finish;
  end

endmodule
